// File: game_cpu.f
hdl/game_cpu_pkg.sv
hdl/wb_if.sv
hdl/register_file.sv
hdl/fetch_unit.sv
hdl/execute_unit.sv
hdl/load_store_unit.sv
hdl/bus_arbiter.sv
hdl/game_cpu.sv
sim/game_cpu_checker.sv
sim/game_cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module game_cpu_tb \
	-f game_cpu.f -o game_cpu_sim
./obj_dir/game_cpu_sim | tee sim.log
grep -q "^STATUS: PASS$" sim.log

// File: sim/game_cpu_tb.sv
`timescale 1ns/1ps

module game_cpu_tb;
	import game_cpu_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int MEM_WORDS = 2048;
	localparam int NUM_TESTS = 4;
	localparam word_t HALT = {5'd17, 3'd7, 8'h00, 16'hffff};

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	word_t wb_dat_r = '0;
	logic wb_ack = 1'b0;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	addr_t wb_adr;
	word_t wb_dat_w;

	word_t mem [MEM_WORDS];
	addr_t exp_addr [$];
	word_t exp_data [$];
	int cursor;
	int store_cnt;
	int n_exp;
	int errors;
	int passed;
	int failed;
	int waits;
	logic pending = 1'b0;
	logic first_seen;
	string cur_name;

	game_cpu i_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////
	// memory model with random wait states
	////////////////////////////////////////////////

	always begin
		@(posedge clk);
		#1;
		if (!rst_n) begin
			wb_ack = 1'b0;
			pending = 1'b0;
		end else if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!pending) begin
				pending = 1'b1;
				waits = $urandom % 4;
			end
			if (waits == 0) begin
				wb_dat_r = mem[wb_adr];
				if (wb_we)
					mem[wb_adr] = wb_dat_w;
				wb_ack = 1'b1;
				pending = 1'b0;
			end else begin
				waits--;
			end
		end
	end

	task automatic check(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			$display("ERROR: time %0t signal %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	// compare process for the first read and every store
	always @(posedge clk) begin
		if (rst_n && wb_cyc && wb_stb && !first_seen) begin
			check("wb_adr", word_t'(wb_adr), 32'd0);
			check("wb_we", word_t'(wb_we), 32'd0);
			first_seen = 1'b1;
		end
		if (rst_n && wb_cyc && wb_stb && wb_we && wb_ack) begin
			if (store_cnt >= n_exp) begin
				$display("unexpected store at time %0t to address %0d", $time, wb_adr);
				errors++;
			end else begin
				check("wb_adr", word_t'(wb_adr), word_t'(exp_addr[store_cnt]));
				check("wb_dat_w", wb_dat_w, exp_data[store_cnt]);
			end
			store_cnt++;
		end
	end

	////////////////////////////////////////////////
	// program builder
	////////////////////////////////////////////////

	function automatic void emit(input word_t w);
		mem[cursor] = w;
		cursor++;
	endfunction

	function automatic word_t enc_r(input int op, input int d, input int s1, input int s2);
		return {op[4:0], d[4:0], s1[4:0], s2[4:0], 12'h000};
	endfunction

	function automatic word_t enc_i(input int op, input int d, input int s1, input int imm);
		return {op[4:0], d[4:0], s1[4:0], 1'b0, imm[15:0]};
	endfunction

	function automatic void emit_branch(input int op, input int cond, input int dst);
		int off;
		off = dst - (cursor + 1);
		emit({op[4:0], cond[2:0], 8'h00, off[15:0]});
	endfunction

	function automatic void load_const(input int d, input word_t v);
		emit(enc_i(11, d, 0, int'(v[15:0])));
		emit(enc_i(12, d, 0, int'(v[31:16])));
	endfunction

	function automatic void clear_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {i[10:0], 10'h155, i[10:0]};
		cursor = 0;
	endfunction

	function automatic void build_alu();
		int ops [8] = '{0, 2, 3, 5, 7, 8, 9, 10};
		load_const(1, 32'h7fff_fff0);
		load_const(2, 32'h0000_0025);
		load_const(3, 32'h8000_1234);
		emit(enc_i(14, 1, 0, 1020));
		for (int k = 0; k < 8; k++) begin
			emit(enc_r(ops[k], 4, 1, 2));
			emit(enc_i(14, 4, 0, 1024 + k));
			emit(enc_r(ops[k], 5, 3, 1));
			emit(enc_i(14, 5, 0, 1040 + k));
		end
		emit(enc_i(1, 4, 1, 16'h0010));
		emit(enc_i(14, 4, 0, 1050));
		emit(enc_i(4, 4, 3, 16'hf0f0));
		emit(enc_i(14, 4, 0, 1051));
		emit(enc_i(6, 4, 2, 16'h8001));
		emit(enc_i(14, 4, 0, 1052));
		// low half write on a register whose upper half is set
		emit(enc_i(11, 1, 0, 16'habcd));
		emit(enc_i(14, 1, 0, 1054));
		// writes aimed at register 0
		emit(enc_i(1, 0, 1, 5));
		emit(enc_r(0, 0, 1, 2));
		emit(enc_i(11, 0, 0, 16'h1234));
		emit(enc_i(14, 0, 0, 1053));
		emit(HALT);
	endfunction

	function automatic void build_mem();
		load_const(1, 32'hcafe_0001);
		emit(enc_i(14, 1, 0, 1030));
		emit(enc_i(13, 2, 0, 1030));
		emit(enc_i(14, 2, 0, 1031));
		load_const(3, 32'd1040);
		emit(enc_i(16, 1, 3, 5));
		emit(enc_i(15, 4, 3, 5));
		emit(enc_i(1, 4, 4, 1));
		emit(enc_i(16, 4, 3, 16'hfffe));
		emit(enc_i(13, 5, 0, 1500));
		emit(enc_i(14, 5, 0, 1032));
		emit(enc_i(15, 6, 3, 0));
		emit(enc_i(14, 6, 0, 1033));
		emit(HALT);
	endfunction

	function automatic void build_branch();
		load_const(1, 32'd5);
		load_const(2, 32'd5);
		load_const(3, 32'hffff_fffd);
		load_const(4, 32'h7fff_ffff);
		load_const(7, 32'h0000_00b0);
		load_const(6, 32'h1111_2222);
		for (int s = 0; s < 4; s++) begin
			case (s)
				0: emit(enc_r(2, 5, 1, 2));
				1: emit(enc_r(0, 5, 1, 2));
				2: emit(enc_r(2, 5, 3, 1));
				default: emit(enc_r(0, 5, 4, 4));
			endcase
			for (int c = 0; c < 8; c++) begin
				emit_branch(17, c, cursor + 2);
				emit(enc_i(14, 7, 0, 1100 + s * 8 + c));
			end
		end
		emit_branch(18, 7, 600);
		emit(enc_i(14, 6, 0, 1200));
		emit(HALT);
		cursor = 600;
		emit(enc_i(14, 6, 0, 1201));
		emit(enc_r(19, 0, 0, 0));
		emit(enc_i(14, 7, 0, 1202));
	endfunction

	function automatic void build_random();
		int r;
		int ops [11] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10};
		for (int i = 1; i < 8; i++)
			load_const(i, $urandom);
		for (int n = 0; n < 40; n++) begin
			r = 1 + $urandom % 7;
			case ($urandom % 4)
				0: load_const(r, $urandom);
				1: begin
					emit(enc_r(ops[$urandom % 11], r, 1 + $urandom % 7, 1 + $urandom % 7));
					emit(enc_i(14, r, 0, 1024 + $urandom % 64));
				end
				2: emit(enc_i(14, r, 0, 1024 + $urandom % 64));
				default: emit(enc_i(13, r, 0, 1024 + $urandom % 64));
			endcase
		end
		emit(HALT);
	endfunction

	////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////

	function automatic void run_reference();
		word_t rm [MEM_WORDS];
		word_t r [32];
		word_t ins;
		word_t a;
		word_t b;
		word_t imm;
		word_t res;
		word_t ea;
		addr_t pc;
		addr_t nxt;
		addr_t link;
		logic fz;
		logic fs;
		logic fo;
		logic tk;
		int op;
		int d;
		longint exact;
		rm = mem;
		foreach (r[i])
			r[i] = '0;
		pc = '0;
		link = '0;
		fz = 1'b0;
		fs = 1'b0;
		fo = 1'b0;
		exp_addr.delete();
		exp_data.delete();
		for (int step = 0; step < 20000; step++) begin
			ins = rm[pc];
			if (ins == HALT)
				break;
			op = int'(ins[31:27]);
			d = int'(ins[26:22]);
			imm = {{16{ins[15]}}, ins[15:0]};
			a = r[ins[21:17]];
			b = (op == 1 || op == 4 || op == 6) ? imm : r[ins[16:12]];
			nxt = pc + 1'b1;
			case (ins[26:24])
				3'd0: tk = !fz;
				3'd1: tk = fz;
				3'd2: tk = !fz && !fs;
				3'd3: tk = !fz && fs;
				3'd4: tk = fz || !fs;
				3'd5: tk = fz || fs;
				3'd6: tk = fo;
				default: tk = 1'b1;
			endcase
			if (op <= 10) begin
				case (op)
					0, 1: res = a + b;
					2: res = a - b;
					3, 4: res = a & b;
					5, 6: res = a | b;
					7: res = a ^ b;
					8: res = a << b[4:0];
					9: res = a >> b[4:0];
					default: res = $signed(a) >>> b[4:0];
				endcase
				// overflow when the exact signed result does not fit in 32 bits
				if (op <= 1)
					exact = longint'($signed(a)) + longint'($signed(b));
				else
					exact = longint'($signed(a)) - longint'($signed(b));
				fo = (op <= 2) && (exact != longint'($signed(res)));
				fz = (res == '0);
				fs = res[31];
				r[d] = res;
			end else begin
				ea = (op == 15 || op == 16) ? a + imm : imm;
				case (op)
					11: r[d][15:0] = imm[15:0];
					12: r[d][31:16] = imm[15:0];
					13, 15: r[d] = rm[ea[10:0]];
					14, 16: begin
						rm[ea[10:0]] = r[d];
						exp_addr.push_back(ea[10:0]);
						exp_data.push_back(r[d]);
					end
					17, 18: if (tk) begin
						if (op == 18)
							link = pc + 1'b1;
						nxt = pc + 1'b1 + imm[10:0];
					end
					19: nxt = link;
					default: ;
				endcase
			end
			r[0] = '0;
			pc = nxt;
		end
	endfunction

	task automatic run_test(input int idx, input string name);
		int errors_before;
		errors_before = errors;
		cur_name = name;
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		clear_memory();
		case (idx)
			0: build_alu();
			1: build_mem();
			2: build_branch();
			default: build_random();
		endcase
		run_reference();
		n_exp = exp_addr.size();
		store_cnt = 0;
		first_seen = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		wait (store_cnt >= n_exp);
		// room for any stray store after the last expected one
		repeat (50) @(posedge clk);
		if (!first_seen) begin
			$display("no bus read seen after reset in test %s", name);
			errors++;
		end
		if (errors == errors_before)
			passed++;
		else
			failed++;
		$display("test %s finished: %0d stores, %0d errors", name, store_cnt,
			errors - errors_before);
	endtask

	initial begin
		#(NUM_TESTS * 4000 * CLK_PERIOD);
		$display("watchdog: test %s hung after %0d of %0d stores", cur_name, store_cnt, n_exp);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(99));
		errors = 0;
		passed = 0;
		failed = 0;
		n_exp = 0;
		store_cnt = 0;
		first_seen = 1'b1;
		cur_name = "none";
		run_test(0, "alu");
		run_test(1, "load_store");
		run_test(2, "branch");
		run_test(3, "random");
		$display("tests %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS, passed, failed,
			errors);
		if (failed == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: sim/game_cpu_checker.sv
`timescale 1ns/1ps

module game_cpu_checker
	import game_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input addr_t wb_adr,
	input word_t wb_dat_w,
	input logic wb_ack
);

	// strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
		else $error("wb_stb high without wb_cyc");

	// master holds its request through wait states
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
		else $error("bus request changed during a wait state");

	bus_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_cyc && !wb_stb)
		else $error("bus active during reset");

endmodule

bind game_cpu game_cpu_checker i_checker (.*);

// File: hdl/game_cpu.sv
`timescale 1ns/1ps

module game_cpu
	import game_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input word_t wb_dat_r,
	input logic wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output addr_t wb_adr,
	output word_t wb_dat_w
);

	logic instr_valid;
	word_t instr;
	addr_t instr_pc;
	logic instr_ready;
	logic redirect;
	addr_t target;
	logic mem_req;
	logic mem_we;
	addr_t mem_addr;
	word_t mem_wdata;
	logic mem_done;
	word_t mem_rdata;

	wb_if instr_bus ();
	wb_if data_bus ();
	wb_if ext_bus ();

	// external port
	assign wb_cyc = ext_bus.cyc;
	assign wb_stb = ext_bus.stb;
	assign wb_we = ext_bus.we;
	assign wb_adr = ext_bus.adr;
	assign wb_dat_w = ext_bus.dat_w;
	assign ext_bus.dat_r = wb_dat_r;
	assign ext_bus.ack = wb_ack;

	fetch_unit i_fetch_unit (
		.clk(clk),
		.rst_n(rst_n),
		.instr_ready(instr_ready),
		.redirect(redirect),
		.target(target),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.bus(instr_bus.master)
	);

	execute_unit i_execute_unit (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_pc(instr_pc),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.instr_ready(instr_ready),
		.redirect(redirect),
		.target(target),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	load_store_unit i_load_store_unit (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_done(mem_done),
		.mem_rdata(mem_rdata),
		.bus(data_bus.master)
	);

	bus_arbiter i_bus_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.data_m(data_bus.slave),
		.instr_m(instr_bus.slave),
		.mem(ext_bus.master)
	);

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
	import game_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	wb_if.slave data_m,
	wb_if.slave instr_m,
	wb_if.master mem
);

	logic instr_grant;
	logic instr_hold;
	logic data_sel;
	logic instr_sel;

	// instruction side keeps the bus while its cycle is open
	assign instr_hold = instr_grant && instr_m.cyc;

	// data wins an idle bus
	assign data_sel = data_m.cyc && !instr_hold;
	assign instr_sel = instr_m.cyc && !data_sel;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			instr_grant <= 1'b0;
		else
			instr_grant <= instr_sel;
	end

	////////////////////////////////////////////////
	// routing
	////////////////////////////////////////////////

	assign mem.cyc = data_sel || instr_sel;
	assign mem.stb = data_sel ? data_m.stb : (instr_sel && instr_m.stb);
	assign mem.we = data_sel && data_m.we;
	assign mem.adr = data_sel ? data_m.adr : instr_m.adr;
	assign mem.dat_w = data_sel ? data_m.dat_w : instr_m.dat_w;

	assign data_m.ack = data_sel && mem.ack;
	assign instr_m.ack = instr_sel && mem.ack;
	assign data_m.dat_r = mem.dat_r;
	assign instr_m.dat_r = mem.dat_r;

endmodule

// File: hdl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
	import game_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic mem_req,
	input logic mem_we,
	input addr_t mem_addr,
	input word_t mem_wdata,
	output logic mem_done,
	output word_t mem_rdata,
	wb_if.master bus
);

	logic done;

	assign done = bus.stb && bus.ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			bus.we <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			// one bus cycle per request
			mem_done <= done;
			if (mem_req) begin
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
				bus.we <= mem_we;
			end else if (done) begin
				bus.cyc <= 1'b0;
				bus.stb <= 1'b0;
				bus.we <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req) begin
			bus.adr <= mem_addr;
			bus.dat_w <= mem_wdata;
		end
		if (done)
			mem_rdata <= bus.dat_r;
	end

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
	import game_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input word_t instr,
	input addr_t instr_pc,
	input logic mem_done,
	input word_t mem_rdata,
	output logic instr_ready,
	output logic redirect,
	output addr_t target,
	output logic mem_req,
	output logic mem_we,
	output addr_t mem_addr,
	output word_t mem_wdata
);

	opcode_t opcode;
	branch_cond_t cond;
	reg_idx_t dest;
	reg_idx_t src1;
	reg_idx_t src2;
	word_t imm;
	word_t rd_data1;
	word_t rd_data2;
	word_t alu_b;
	word_t alu_result;
	word_t eff_addr;
	word_t wr_data;
	reg_idx_t wr_addr;
	reg_idx_t ld_dest;
	alu_op_t alu_op;
	exec_state_t state;
	addr_t link_reg;
	logic accept;
	logic is_alu;
	logic use_imm;
	logic is_load;
	logic is_store;
	logic use_offset;
	logic is_branch;
	logic is_ret;
	logic taken;
	logic alu_overflow;
	logic flag_zero;
	logic flag_sign;
	logic flag_overflow;
	logic ld_pending;
	logic wr_full;
	logic wr_lower;
	logic wr_upper;

	////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////

	assign opcode = opcode_t'(instr[31:27]);
	assign dest = instr[26:22];
	assign cond = branch_cond_t'(instr[26:24]);
	assign src1 = instr[21:17];
	assign src2 = instr[16:12];
	assign imm = {{16{instr[15]}}, instr[15:0]};

	assign is_alu = opcode inside {[op_add:op_sra]};
	assign use_imm = opcode inside {op_addi, op_andi, op_ori};
	assign is_load = opcode inside {op_lw, op_lwo};
	assign is_store = opcode inside {op_sw, op_swo};
	assign use_offset = opcode inside {op_lwo, op_swo};
	assign is_branch = opcode inside {op_b, op_bl};
	assign is_ret = (opcode == op_ret);

	assign instr_ready = (state == exec_issue);
	assign accept = instr_valid && instr_ready;

	////////////////////////////////////////////////
	// alu and flags
	////////////////////////////////////////////////

	assign alu_b = use_imm ? imm : rd_data2;

	always_comb begin
		case (opcode)
			op_sub: alu_op = alu_sub;
			op_and, op_andi: alu_op = alu_and;
			op_or, op_ori: alu_op = alu_or;
			op_xor: alu_op = alu_xor;
			op_sll: alu_op = alu_sll;
			op_srl: alu_op = alu_srl;
			op_sra: alu_op = alu_sra;
			default: alu_op = alu_add;
		endcase
	end

	always_comb begin
		alu_overflow = 1'b0;
		case (alu_op)
			alu_add: begin
				alu_result = rd_data1 + alu_b;
				alu_overflow = (rd_data1[31] == alu_b[31]) && (alu_result[31] != rd_data1[31]);
			end
			alu_sub: begin
				alu_result = rd_data1 - alu_b;
				alu_overflow = (rd_data1[31] != alu_b[31]) && (alu_result[31] != rd_data1[31]);
			end
			alu_and: alu_result = rd_data1 & alu_b;
			alu_or: alu_result = rd_data1 | alu_b;
			alu_xor: alu_result = rd_data1 ^ alu_b;
			alu_sll: alu_result = rd_data1 << alu_b[4:0];
			alu_srl: alu_result = rd_data1 >> alu_b[4:0];
			default: alu_result = $signed(rd_data1) >>> alu_b[4:0];
		endcase
	end

	// branch test on the flags left by the last alu op
	always_comb begin
		case (cond)
			cond_ne: taken = !flag_zero;
			cond_eq: taken = flag_zero;
			cond_gt: taken = !flag_zero && !flag_sign;
			cond_lt: taken = !flag_zero && flag_sign;
			cond_ge: taken = flag_zero || !flag_sign;
			cond_le: taken = flag_zero || flag_sign;
			cond_overflow: taken = flag_overflow;
			default: taken = 1'b1;
		endcase
	end

	assign redirect = is_ret || (is_branch && taken);
	assign target = is_ret ? link_reg : instr_pc + 1'b1 + imm[ADDR_W-1:0];

	// memory request, store data comes from dest
	assign eff_addr = use_offset ? rd_data1 + imm : imm;
	assign mem_req = accept && (is_load || is_store);
	assign mem_we = is_store;
	assign mem_addr = eff_addr[ADDR_W-1:0];
	assign mem_wdata = rd_data2;

	// write back, load data arrives in the wait state
	assign wr_addr = (state == exec_mem_wait) ? ld_dest : dest;
	assign wr_data = (state == exec_mem_wait) ? mem_rdata : (is_alu ? alu_result : imm);
	assign wr_full = (accept && is_alu) || (state == exec_mem_wait && mem_done && ld_pending);
	assign wr_lower = accept && (opcode == op_lli);
	assign wr_upper = accept && (opcode == op_lui);

	register_file i_register_file (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr1(src1),
		.rd_addr2(is_store ? dest : src2),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_full(wr_full),
		.wr_lower(wr_lower),
		.wr_upper(wr_upper),
		.rd_data1(rd_data1),
		.rd_data2(rd_data2)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= exec_issue;
			ld_pending <= 1'b0;
			flag_zero <= 1'b0;
			flag_sign <= 1'b0;
			flag_overflow <= 1'b0;
			link_reg <= '0;
		end else begin
			if (accept && is_alu) begin
				flag_zero <= (alu_result == '0);
				flag_sign <= alu_result[31];
				flag_overflow <= alu_overflow;
			end
			if (accept && opcode == op_bl && taken)
				link_reg <= instr_pc + 1'b1;
			case (state)
				exec_issue:
					if (mem_req) begin
						state <= exec_mem_wait;
						ld_pending <= is_load;
					end
				default:
					if (mem_done)
						state <= exec_issue;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req)
			ld_dest <= dest;
	end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
	import game_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic instr_ready,
	input logic redirect,
	input addr_t target,
	output logic instr_valid,
	output word_t instr,
	output addr_t instr_pc,
	wb_if.master bus
);

	addr_t fetch_pc;
	logic pf_valid;
	word_t pf_instr;
	addr_t pf_pc;
	logic drop;
	logic accept;
	logic flush;
	logic done;
	logic take;
	logic issue;
	logic load_cur;
	logic load_pf;
	addr_t issue_addr;

	assign accept = instr_valid && instr_ready;
	assign flush = accept && redirect;
	assign done = bus.stb && bus.ack;

	// a returning word is kept unless a redirect made it stale
	assign take = done && !drop && !flush;
	assign load_cur = take && (!instr_valid || accept);
	assign load_pf = take && instr_valid && !accept;

	// prefetch only has to be empty once this cycle's accept is done
	assign issue = !bus.cyc && (!pf_valid || accept);
	assign issue_addr = flush ? target : fetch_pc;

	// instruction reads only
	assign bus.we = 1'b0;
	assign bus.dat_w = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			fetch_pc <= '0;
			instr_valid <= 1'b0;
			pf_valid <= 1'b0;
			drop <= 1'b0;
		end else begin
			if (done) begin
				bus.cyc <= 1'b0;
				bus.stb <= 1'b0;
				drop <= 1'b0;
			end else if (issue) begin
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
			end
			// cycle in flight keeps running, its word is thrown away
			if (flush && bus.cyc && !bus.ack)
				drop <= 1'b1;

			if (issue)
				fetch_pc <= issue_addr + 1'b1;
			else if (flush)
				fetch_pc <= target;

			if (flush)
				instr_valid <= 1'b0;
			else if (load_cur)
				instr_valid <= 1'b1;
			else if (accept)
				instr_valid <= pf_valid;

			if (flush || accept)
				pf_valid <= 1'b0;
			else if (load_pf)
				pf_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			bus.adr <= issue_addr;
		if (load_cur) begin
			instr <= bus.dat_r;
			instr_pc <= bus.adr;
		end else if (accept) begin
			instr <= pf_instr;
			instr_pc <= pf_pc;
		end
		if (load_pf) begin
			pf_instr <= bus.dat_r;
			pf_pc <= bus.adr;
		end
	end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file
	import game_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input reg_idx_t rd_addr1,
	input reg_idx_t rd_addr2,
	input reg_idx_t wr_addr,
	input word_t wr_data,
	input logic wr_full,
	input logic wr_lower,
	input logic wr_upper,
	output word_t rd_data1,
	output word_t rd_data2
);

	word_t regs [32];

	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_addr != '0) begin
			// half writes take the low half of wr_data
			if (wr_full)
				regs[wr_addr] <= wr_data;
			else if (wr_lower)
				regs[wr_addr][15:0] <= wr_data[15:0];
			else if (wr_upper)
				regs[wr_addr][31:16] <= wr_data[15:0];
		end
	end

endmodule

// File: hdl/wb_if.sv
`timescale 1ns/1ps

interface wb_if
	import game_cpu_pkg::*;
();

	logic cyc;
	logic stb;
	logic we;
	addr_t adr;
	word_t dat_w;
	word_t dat_r;
	logic ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input dat_r, ack
	);

	modport slave (
		input cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

// File: hdl/game_cpu_pkg.sv
package game_cpu_pkg;

	localparam int ADDR_W = 11;
	localparam int WORD_W = 32;
	localparam int REG_IDX_W = 5;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// opcodes that are not listed run as no-ops
	typedef enum logic [4:0] {
		op_add  = 5'd0,
		op_addi = 5'd1,
		op_sub  = 5'd2,
		op_and  = 5'd3,
		op_andi = 5'd4,
		op_or   = 5'd5,
		op_ori  = 5'd6,
		op_xor  = 5'd7,
		op_sll  = 5'd8,
		op_srl  = 5'd9,
		op_sra  = 5'd10,
		op_lli  = 5'd11,
		op_lui  = 5'd12,
		op_lw   = 5'd13,
		op_sw   = 5'd14,
		op_lwo  = 5'd15,
		op_swo  = 5'd16,
		op_b    = 5'd17,
		op_bl   = 5'd18,
		op_ret  = 5'd19
	} opcode_t;

	// branch condition field, bits 26..24
	typedef enum logic [2:0] {
		cond_ne,
		cond_eq,
		cond_gt,
		cond_lt,
		cond_ge,
		cond_le,
		cond_overflow,
		cond_always
	} branch_cond_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_t;

	typedef enum logic {
		exec_issue,
		exec_mem_wait
	} exec_state_t;

endpackage
